//--- Makefile
# Verilator simulation of the AXI write upsizer
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_axi_write_upsizer
FILELIST  = sim.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tb_axi_write_upsizer.sv
/* Burst table run through the upsizer under random back-pressure from a seeded LFSR.
   W strobes are random per beat; lanes without strobe are not compared. */
`default_nettype none

module tb_axi_write_upsizer import upsize_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RST_CYCLES = 16;
  localparam int N_TESTS    = 11;

  logic clk_i;
  logic rst_ni;
  id_t in_aw_id;
  addr_t in_aw_addr;
  len_t in_aw_len;
  size_t in_aw_size;
  burst_e in_aw_burst;
  cache_t in_aw_cache;
  logic in_aw_valid, in_aw_ready;
  narrow_data_t in_w_data;
  narrow_strb_t in_w_strb;
  logic in_w_valid, in_w_ready;
  id_t in_b_id, out_b_id, out_aw_id;
  resp_t in_b_resp, out_b_resp;
  logic in_b_valid, in_b_ready, out_b_valid, out_b_ready;
  addr_t out_aw_addr;
  len_t out_aw_len;
  size_t out_aw_size;
  burst_e out_aw_burst;
  cache_t out_aw_cache;
  logic out_aw_valid, out_aw_ready;
  wide_data_t out_w_data;
  wide_strb_t out_w_strb;
  logic out_w_last, out_w_valid, out_w_ready;

  // Burst table, one row per test
  string  t_name [N_TESTS];
  addr_t  t_addr [N_TESTS];
  len_t   t_len [N_TESTS];
  size_t  t_size [N_TESTS];
  burst_e t_burst [N_TESTS];
  cache_t t_cache [N_TESTS];
  id_t    t_id [N_TESTS];
  len_t   t_exp_len [N_TESTS];
  size_t  t_exp_size [N_TESTS];
  int     n_rows;

  wide_data_t   exp_data_q[$];
  wide_strb_t   exp_strb_q[$];
  logic         exp_last_q[$];
  narrow_data_t beat_q[$];
  narrow_strb_t beat_strb_q[$];

  logic [31:0] lfsr_q;
  string cur_name;
  int test_errors, total_errors, tests_run, tests_passed;
  int cycle_count, cycle_limit;

  axi_write_upsizer dut0 (
    .clk_i, .rst_ni,
    .in_aw_id, .in_aw_addr, .in_aw_len, .in_aw_size, .in_aw_burst, .in_aw_cache,
    .in_aw_valid, .in_aw_ready, .in_w_data, .in_w_strb, .in_w_valid, .in_w_ready,
    .in_b_id, .in_b_resp, .in_b_valid, .in_b_ready,
    .out_aw_id, .out_aw_addr, .out_aw_len, .out_aw_size, .out_aw_burst, .out_aw_cache,
    .out_aw_valid, .out_aw_ready, .out_w_data, .out_w_strb, .out_w_last, .out_w_valid,
    .out_w_ready, .out_b_id, .out_b_resp, .out_b_valid, .out_b_ready
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #50 clk_i = ~clk_i;
    end
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  task automatic add_row(input string name, input addr_t addr, input len_t len,
                         input size_t size, input burst_e burst, input cache_t cache,
                         input id_t id, input len_t exp_len, input size_t exp_size);
    t_name[n_rows] = name;
    t_addr[n_rows] = addr;
    t_len[n_rows] = len;
    t_size[n_rows] = size;
    t_burst[n_rows] = burst;
    t_cache[n_rows] = cache;
    t_id[n_rows] = id;
    t_exp_len[n_rows] = exp_len;
    t_exp_size[n_rows] = exp_size;
    n_rows++;
  endtask

  task automatic check_value(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    assert (exp_v === act_v) else begin
      $display("error %s %s: expected %0h, actual %0h", cur_name, what, exp_v, act_v);
      test_errors++;
    end
  endtask

  function automatic int compute_limit();
    int lim;
    lim = RST_CYCLES;
    for (int i = 0; i < n_rows; i++) begin
      lim += 6 * (int'(t_len[i]) + 1) + 20;
    end
    return lim;
  endfunction

  // Reference model: lane rule per beat, merge until the wide word is left
  task automatic build_expected(input int idx);
    addr_t a, na;
    int off, nof, src, nbytes;
    logic upsize, is_last;
    wide_data_t wd;
    wide_strb_t ws;
    logic [31:0] r;
    logic [31:0] rs;
    exp_data_q.delete();
    exp_strb_q.delete();
    exp_last_q.delete();
    beat_q.delete();
    beat_strb_q.delete();
    // Cache bit 1 marks a modifiable burst
    upsize = t_cache[idx][1] && (t_burst[idx] == BURST_INCR);
    nbytes = 1 << t_size[idx];
    a = t_addr[idx];
    wd = '0;
    ws = '0;
    for (int k = 0; k <= int'(t_len[idx]); k++) begin
      take_bits(32, r);
      beat_q.push_back(r);
      take_bits(4, rs);
      beat_strb_q.push_back(rs[3:0]);
      off = int'(a[2:0]);
      nof = int'(a[1:0]);
      for (int b = 0; b < 8; b++) begin
        src = b - off + nof;
        if ((b >= off) && (b - off < nbytes) && (src < 4)) begin
          wd[8*b +: 8] = r[8*src +: 8];
          ws[b] = rs[src];
        end
      end
      na = (a & ~addr_t'(nbytes - 1)) + addr_t'(nbytes);
      is_last = (k == int'(t_len[idx]));
      if (!upsize || is_last || (na[31:3] != a[31:3])) begin
        exp_data_q.push_back(wd);
        exp_strb_q.push_back(ws);
        exp_last_q.push_back(is_last);
        wd = '0;
        ws = '0;
      end
      a = na;
    end
  endtask

  // ----------------------------------------------------------
  // One burst: drive, sample at the falling edge, compare
  // ----------------------------------------------------------
  task automatic run_test(input int idx);
    int aw_seen, beat_idx, words_total, words_seen;
    logic aw_taken, done;
    logic [31:0] r;
    wide_data_t mask;
    cur_name = t_name[idx];
    test_errors = 0;
    build_expected(idx);
    words_total = exp_data_q.size();
    aw_seen = 0;
    beat_idx = 0;
    words_seen = 0;
    aw_taken = 1'b0;
    done = 1'b0;
    in_aw_id = t_id[idx];
    in_aw_addr = t_addr[idx];
    in_aw_len = t_len[idx];
    in_aw_size = t_size[idx];
    in_aw_burst = t_burst[idx];
    in_aw_cache = t_cache[idx];
    in_aw_valid = 1'b1;
    while (!done) begin
      in_w_valid = (beat_idx < beat_q.size());
      in_w_data = '0;
      in_w_strb = '0;
      if (in_w_valid) begin
        in_w_data = beat_q[beat_idx];
        in_w_strb = beat_strb_q[beat_idx];
      end
      take_bits(2, r);
      out_aw_ready = |r[1:0];
      take_bits(2, r);
      out_w_ready = |r[1:0];
      take_bits(8, r);
      out_b_id = r[3:0];
      out_b_resp = r[5:4];
      out_b_valid = r[6];
      in_b_ready = r[7];
      @(negedge clk_i);
      check_value("b_id", 64'(out_b_id), 64'(in_b_id));
      check_value("b_resp", 64'(out_b_resp), 64'(in_b_resp));
      check_value("b_valid", 64'(out_b_valid), 64'(in_b_valid));
      check_value("b_ready", 64'(in_b_ready), 64'(out_b_ready));
      if (in_aw_valid && in_aw_ready) begin
        aw_taken = 1'b1;
      end
      if (in_w_valid && in_w_ready) begin
        beat_idx++;
      end
      if (out_aw_valid && out_aw_ready) begin
        assert (aw_seen == 0) else begin
          $display("%s: a second wide AW request was issued for one burst", cur_name);
          test_errors++;
        end
        aw_seen++;
        check_value("aw_id", 64'(t_id[idx]), 64'(out_aw_id));
        check_value("aw_addr", 64'(t_addr[idx]), 64'(out_aw_addr));
        check_value("aw_len", 64'(t_exp_len[idx]), 64'(out_aw_len));
        check_value("aw_size", 64'(t_exp_size[idx]), 64'(out_aw_size));
        check_value("aw_burst", 64'(t_burst[idx]), 64'(out_aw_burst));
        check_value("aw_cache", 64'(t_cache[idx]), 64'(out_aw_cache));
      end
      if (out_w_valid && out_w_ready) begin
        assert (exp_data_q.size() > 0) else begin
          $display("%s: a wide W word arrived after all expected words", cur_name);
          test_errors++;
        end
        if (exp_data_q.size() > 0) begin
          for (int b = 0; b < 8; b++) begin
            mask[8*b +: 8] = {8{exp_strb_q[0][b]}};
          end
          check_value("w_strb", 64'(exp_strb_q[0]), 64'(out_w_strb));
          check_value("w_data", exp_data_q[0] & mask, out_w_data & mask);
          check_value("w_last", 64'(exp_last_q[0]), 64'(out_w_last));
          void'(exp_data_q.pop_front());
          void'(exp_strb_q.pop_front());
          void'(exp_last_q.pop_front());
        end
        words_seen++;
      end
      done = aw_taken && (words_seen >= words_total) && in_aw_ready;
      @(posedge clk_i);
      #10;
      if (aw_taken) begin
        in_aw_valid = 1'b0;
      end
    end
    assert (aw_seen == 1) else begin
      $display("%s: the wide AW request never left the converter", cur_name);
      test_errors++;
    end
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      tests_passed++;
    end
    $display("test %s: %0d beats, %0d words, %0d errors", cur_name, beat_q.size(),
             words_total, test_errors);
  endtask

  // Run limit from the table length
  initial begin
    cycle_count = 0;
    @(posedge clk_i);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: run did not finish within %0d clock cycles", cycle_limit);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst_ni = 1'b0;
    in_aw_id = '0;
    in_aw_addr = '0;
    in_aw_len = '0;
    in_aw_size = '0;
    in_aw_burst = BURST_INCR;
    in_aw_cache = '0;
    in_aw_valid = 1'b0;
    in_w_data = '0;
    in_w_strb = '0;
    in_w_valid = 1'b0;
    in_b_ready = 1'b0;
    out_aw_ready = 1'b0;
    out_w_ready = 1'b0;
    out_b_id = '0;
    out_b_resp = '0;
    out_b_valid = 1'b0;
    lfsr_q = 32'ha2c;
    n_rows = 0;
    test_errors = 0;
    total_errors = 0;
    tests_run = 0;
    tests_passed = 0;
    //      name                 addr      len    size  burst        cache id     len    size
    add_row("incr_aligned_s2",   32'h1000, 8'd7,  3'd2, BURST_INCR,  4'h2, 4'h1, 8'd3,  3'd3);
    add_row("incr_off4_s2",      32'h2004, 8'd4,  3'd2, BURST_INCR,  4'h2, 4'h2, 8'd2,  3'd3);
    add_row("incr_s1",           32'h3002, 8'd6,  3'd1, BURST_INCR,  4'h3, 4'h3, 8'd1,  3'd3);
    add_row("incr_s0",           32'h4005, 8'd5,  3'd0, BURST_INCR,  4'h2, 4'h4, 8'd1,  3'd3);
    add_row("incr_unaligned_s2", 32'h5006, 8'd2,  3'd2, BURST_INCR,  4'hf, 4'h5, 8'd1,  3'd3);
    add_row("incr_long",         32'h6000, 8'd15, 3'd2, BURST_INCR,  4'h2, 4'h6, 8'd7,  3'd3);
    add_row("incr_single",       32'ha004, 8'd0,  3'd2, BURST_INCR,  4'h2, 4'h7, 8'd0,  3'd3);
    add_row("incr_nonmod",       32'h7000, 8'd3,  3'd2, BURST_INCR,  4'h0, 4'h8, 8'd3,  3'd2);
    add_row("fixed_mod",         32'h8004, 8'd3,  3'd2, BURST_FIXED, 4'h2, 4'h9, 8'd3,  3'd2);
    add_row("wrap_mod",          32'h9008, 8'd3,  3'd2, BURST_WRAP,  4'h3, 4'ha, 8'd3,  3'd2);
    add_row("pass_s0",           32'hb003, 8'd2,  3'd0, BURST_INCR,  4'h1, 4'hb, 8'd2,  3'd0);
    cycle_limit = compute_limit();

    repeat (RST_CYCLES) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    @(negedge clk_i);
    cur_name = "reset";
    check_value("in_aw_ready", 64'(1'b1), 64'(in_aw_ready));
    check_value("out_aw_valid", 64'(1'b0), 64'(out_aw_valid));
    check_value("in_w_ready", 64'(1'b0), 64'(in_w_ready));
    check_value("out_w_valid", 64'(1'b0), 64'(out_w_valid));
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      tests_passed++;
    end
    $display("test reset: %0d errors", test_errors);
    @(posedge clk_i);
    #10;

    for (int i = 0; i < n_rows; i++) begin
      run_test(i);
    end

    $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run, tests_passed,
             tests_run - tests_passed, total_errors);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/upsizer_asserts.sv
/* Handshake stability and channel ordering checks on the write upsizer.
   Checks are held off while rst_ni is low. */
`default_nettype none

module upsizer_asserts import upsize_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       in_aw_ready,
  input logic       in_w_ready,
  input id_t        out_aw_id,
  input addr_t      out_aw_addr,
  input len_t       out_aw_len,
  input size_t      out_aw_size,
  input burst_e     out_aw_burst,
  input cache_t     out_aw_cache,
  input logic       out_aw_valid,
  input logic       out_aw_ready,
  input wide_data_t out_w_data,
  input wide_strb_t out_w_strb,
  input logic       out_w_last,
  input logic       out_w_valid,
  input logic       out_w_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------------------------
  // Valid and payload hold until the handshake
  // ----------------------------------------------------------
  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_aw_valid && !out_aw_ready) |=> (out_aw_valid && $stable({out_aw_id, out_aw_addr,
      out_aw_len, out_aw_size, out_aw_burst, out_aw_cache})))
    else $error("out_aw valid or fields changed before out_aw_ready");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_w_valid && !out_w_ready) |=>
      (out_w_valid && $stable({out_w_data, out_w_strb, out_w_last})))
    else $error("out_w valid, data, strb or last changed before out_w_ready");

  // W beats only after the wide AW has left
  w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_w_ready && out_aw_valid))
    else $error("in_w_ready high while out_aw_valid is still pending");

  aw_after_w: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(in_aw_ready && out_w_valid))
    else $error("in_aw_ready high while a wide W word is still pending");

endmodule

bind axi_write_upsizer upsizer_asserts asserts0 (
  .clk_i, .rst_ni, .in_aw_ready, .in_w_ready,
  .out_aw_id, .out_aw_addr, .out_aw_len, .out_aw_size, .out_aw_burst, .out_aw_cache,
  .out_aw_valid, .out_aw_ready,
  .out_w_data, .out_w_strb, .out_w_last, .out_w_valid, .out_w_ready
);

`default_nettype wire

//--- rtl/aw_burst_planner.sv
/* One AW burst in flight; a new request is taken only once the mode is idle.
   Modifiable INCR bursts become full 64-bit beats, others pass unchanged. */
`default_nettype none

module aw_burst_planner import upsize_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,

  input  id_t      in_aw_id,
  input  addr_t    in_aw_addr,
  input  len_t     in_aw_len,
  input  size_t    in_aw_size,
  input  burst_e   in_aw_burst,
  input  cache_t   in_aw_cache,
  input  logic     in_aw_valid,
  output logic     in_aw_ready,

  output id_t      out_aw_id,
  output addr_t    out_aw_addr,
  output len_t     out_aw_len,
  output size_t    out_aw_size,
  output burst_e   out_aw_burst,
  output cache_t   out_aw_cache,
  output logic     out_aw_valid,
  input  logic     out_aw_ready,

  input  logic     burst_done,

  output logic     start,
  output addr_t    start_addr,
  output len_t     start_len,
  output size_t    start_size,
  output wr_mode_e mode
);

  wr_mode_e mode_q;
  logic     aw_valid_q;
  logic     upsize;
  logic     accept;
  addr_t    size_mask;
  addr_t    addr_first;
  addr_t    addr_final;
  len_t     wide_len;

  // Captured request
  id_t      id_q;
  addr_t    addr_q;
  len_t     len_q;
  size_t    size_q;
  len_t     out_len_q;
  size_t    out_size_q;
  burst_e   burst_q;
  cache_t   cache_q;

  // ----------------------------------------------------------
  // Wide burst length from aligned first and final addresses
  // ----------------------------------------------------------
  assign size_mask  = (addr_t'(1) << in_aw_size) - addr_t'(1);
  assign addr_first = in_aw_addr & ~addr_t'(WIDE_BYTES - 1);
  assign addr_final = ((in_aw_addr & ~size_mask) + (addr_t'(in_aw_len) << in_aw_size))
                      & ~addr_t'(WIDE_BYTES - 1);
  assign wide_len   = len_t'((addr_final - addr_first) >> WIDE_SIZE);

  assign upsize = ((in_aw_cache & CACHE_MODIFIABLE) != '0) && (in_aw_burst == BURST_INCR);

  assign in_aw_ready = (mode_q == MODE_IDLE);
  assign accept      = in_aw_valid && in_aw_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q     <= MODE_IDLE;
      aw_valid_q <= 1'b0;
    end else begin
      if (accept) begin
        mode_q     <= upsize ? MODE_INCR_UPSIZE : MODE_PASSTHROUGH;
        aw_valid_q <= 1'b1;
      end else begin
        if (out_aw_valid && out_aw_ready) begin
          aw_valid_q <= 1'b0;
        end
        if (burst_done) begin
          mode_q <= MODE_IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_t_cap: begin
        id_q       <= in_aw_id;
        addr_q     <= in_aw_addr;
        len_q      <= in_aw_len;
        size_q     <= in_aw_size;
        burst_q    <= in_aw_burst;
        cache_q    <= in_aw_cache;
        out_len_q  <= upsize ? wide_len : in_aw_len;
        out_size_q <= upsize ? WIDE_SIZE : in_aw_size;
      end
    end
  end

  assign out_aw_id    = id_q;
  assign out_aw_addr  = addr_q;
  assign out_aw_len   = out_len_q;
  assign out_aw_size  = out_size_q;
  assign out_aw_burst = burst_q;
  assign out_aw_cache = cache_q;
  assign out_aw_valid = aw_valid_q;

  // Narrow view of the burst for the W path
  assign start      = out_aw_valid && out_aw_ready;
  assign start_addr = addr_q;
  assign start_len  = len_q;
  assign start_size = size_q;
  assign mode       = mode_q;

endmodule

`default_nettype wire

//--- rtl/axi_write_upsizer.sv
/* AXI write upsizer, 32-bit manager to 64-bit subordinate, one burst at a time.
   Lock, prot, qos, region, atop and user signals are not carried. */
`default_nettype none

module axi_write_upsizer import upsize_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  // Manager side
  input  id_t          in_aw_id,
  input  addr_t        in_aw_addr,
  input  len_t         in_aw_len,
  input  size_t        in_aw_size,
  input  burst_e       in_aw_burst,
  input  cache_t       in_aw_cache,
  input  logic         in_aw_valid,
  output logic         in_aw_ready,

  input  narrow_data_t in_w_data,
  input  narrow_strb_t in_w_strb,
  input  logic         in_w_valid,
  output logic         in_w_ready,

  output id_t          in_b_id,
  output resp_t        in_b_resp,
  output logic         in_b_valid,
  input  logic         in_b_ready,

  // Subordinate side
  output id_t          out_aw_id,
  output addr_t        out_aw_addr,
  output len_t         out_aw_len,
  output size_t        out_aw_size,
  output burst_e       out_aw_burst,
  output cache_t       out_aw_cache,
  output logic         out_aw_valid,
  input  logic         out_aw_ready,

  output wide_data_t   out_w_data,
  output wide_strb_t   out_w_strb,
  output logic         out_w_last,
  output logic         out_w_valid,
  input  logic         out_w_ready,

  input  id_t          out_b_id,
  input  resp_t        out_b_resp,
  input  logic         out_b_valid,
  output logic         out_b_ready
);

  logic       start;
  addr_t      start_addr;
  len_t       start_len;
  size_t      start_size;
  wr_mode_e   mode;
  wide_data_t lane_data;
  wide_strb_t lane_strb;
  logic       lane_write;
  logic       word_flush;
  logic       word_last;
  logic       buf_ready;
  logic       burst_done;

  aw_burst_planner planner0 (
    .clk_i, .rst_ni,
    .in_aw_id, .in_aw_addr, .in_aw_len, .in_aw_size, .in_aw_burst, .in_aw_cache,
    .in_aw_valid, .in_aw_ready,
    .out_aw_id, .out_aw_addr, .out_aw_len, .out_aw_size, .out_aw_burst, .out_aw_cache,
    .out_aw_valid, .out_aw_ready,
    .burst_done,
    .start, .start_addr, .start_len, .start_size, .mode
  );

  w_lane_steer steer0 (
    .clk_i, .rst_ni,
    .start, .start_addr, .start_len, .start_size, .mode,
    .in_w_data, .in_w_strb, .in_w_valid, .in_w_ready,
    .buf_ready,
    .lane_data, .lane_strb, .lane_write, .word_flush, .word_last
  );

  w_word_buffer buffer0 (
    .clk_i, .rst_ni,
    .lane_data, .lane_strb, .lane_write, .word_flush, .word_last,
    .buf_ready,
    .out_w_data, .out_w_strb, .out_w_last, .out_w_valid, .out_w_ready,
    .burst_done
  );

  // B passes through with no latency
  assign in_b_id     = out_b_id;
  assign in_b_resp   = out_b_resp;
  assign in_b_valid  = out_b_valid;
  assign out_b_ready = in_b_ready;

endmodule

`default_nettype wire

//--- rtl/upsize_pkg.sv
/* Fixed 32-bit to 64-bit write upsizer widths and AXI field types.
   Only the write path fields the converter handles are defined. */
`default_nettype none

package upsize_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned ADDR_WIDTH        = 32;
  localparam int unsigned ID_WIDTH          = 4;
  localparam int unsigned NARROW_DATA_WIDTH = 32;
  localparam int unsigned WIDE_DATA_WIDTH   = 64;
  localparam int unsigned NARROW_BYTES      = NARROW_DATA_WIDTH / 8;
  localparam int unsigned WIDE_BYTES        = WIDE_DATA_WIDTH / 8;

  // ----------------------------------------------------------
  // AXI field types
  // ----------------------------------------------------------
  typedef logic [ADDR_WIDTH-1:0]        addr_t;
  typedef logic [ID_WIDTH-1:0]          id_t;
  typedef logic [7:0]                   len_t;
  typedef logic [2:0]                   size_t;
  typedef logic [3:0]                   cache_t;
  typedef logic [1:0]                   resp_t;
  typedef logic [NARROW_DATA_WIDTH-1:0] narrow_data_t;
  typedef logic [NARROW_BYTES-1:0]      narrow_strb_t;
  typedef logic [WIDE_DATA_WIDTH-1:0]   wide_data_t;
  typedef logic [WIDE_BYTES-1:0]        wide_strb_t;

  // Size code of one full wide beat
  localparam size_t  WIDE_SIZE        = 3'd3;
  // Modifiable bit of AxCACHE
  localparam cache_t CACHE_MODIFIABLE = 4'b0010;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } burst_e;

  // Write FSM state, also selects how beats are merged
  typedef enum logic [1:0] {
    MODE_IDLE        = 2'b00,
    MODE_PASSTHROUGH = 2'b01,
    MODE_INCR_UPSIZE = 2'b10
  } wr_mode_e;

endpackage

`default_nettype wire

//--- rtl/w_lane_steer.sv
/* Narrow W beats are steered combinationally; only the beat tracking is
   registered. start_* and mode must stay stable while beats are pending. */
`default_nettype none

module w_lane_steer import upsize_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         start,
  input  addr_t        start_addr,
  input  len_t         start_len,
  input  size_t        start_size,
  input  wr_mode_e     mode,

  input  narrow_data_t in_w_data,
  input  narrow_strb_t in_w_strb,
  input  logic         in_w_valid,
  output logic         in_w_ready,

  input  logic         buf_ready,

  output wide_data_t   lane_data,
  output wide_strb_t   lane_strb,
  output logic         lane_write,
  output logic         word_flush,
  output logic         word_last
);

  addr_t      addr_q;
  len_t       remaining_q;
  logic       pending_q;
  logic       beat_fire;
  logic [7:0] beat_bytes;
  addr_t      size_mask;
  addr_t      next_addr;
  logic [2:0] wide_off;
  logic [1:0] narrow_off;
  logic       leaves_word;

  assign in_w_ready = pending_q && buf_ready;
  assign beat_fire  = in_w_valid && in_w_ready;

  assign beat_bytes = 8'(1) << start_size;
  assign size_mask  = addr_t'(beat_bytes) - addr_t'(1);
  assign next_addr  = (addr_q & ~size_mask) + addr_t'(beat_bytes);
  assign wide_off   = addr_q[2:0];
  assign narrow_off = addr_q[1:0];

  // ----------------------------------------------------------
  // Byte lane steering
  // ----------------------------------------------------------
  always_comb begin
    int src;
    lane_data = '0;
    lane_strb = '0;
    for (int b = 0; b < WIDE_BYTES; b++) begin
      // Narrow lane feeding wide lane b
      src = b - int'(wide_off) + int'(narrow_off);
      if ((b >= int'(wide_off)) && (b - int'(wide_off) < int'(beat_bytes)) &&
          (src < int'(NARROW_BYTES))) begin
        lane_data[8*b +: 8] = in_w_data[8*src +: 8];
        lane_strb[b]        = in_w_strb[src];
      end
    end
  end

  // Word is done once the next beat lands in another 64-bit word
  assign leaves_word = (next_addr[ADDR_WIDTH-1:3] != addr_q[ADDR_WIDTH-1:3]);

  assign lane_write = beat_fire;
  assign word_last  = (remaining_q == '0);
  assign word_flush = beat_fire &&
                      ((mode == MODE_PASSTHROUGH) || word_last || leaves_word);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q      <= '0;
      remaining_q <= '0;
      pending_q   <= 1'b0;
    end else if (start) begin
      addr_q      <= start_addr;
      remaining_q <= start_len;
      pending_q   <= 1'b1;
    end else if (beat_fire) begin
      addr_q      <= next_addr;
      remaining_q <= remaining_q - len_t'(1);
      if (word_last) begin
        pending_q <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/w_word_buffer.sv
/* Single wide W word register; accepts a new merge in the cycle it is read.
   Bytes with a low strobe keep stale data and are masked by out_w_strb. */
`default_nettype none

module w_word_buffer import upsize_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  wide_data_t lane_data,
  input  wide_strb_t lane_strb,
  input  logic       lane_write,
  input  logic       word_flush,
  input  logic       word_last,

  output logic       buf_ready,

  output wide_data_t out_w_data,
  output wide_strb_t out_w_strb,
  output logic       out_w_last,
  output logic       out_w_valid,
  input  logic       out_w_ready,

  output logic       burst_done
);

  wide_data_t data_q;
  wide_strb_t strb_q;
  logic       last_q;
  logic       valid_q;
  logic       accept;

  assign accept    = valid_q && out_w_ready;
  assign buf_ready = !valid_q || out_w_ready;

  // ----------------------------------------------------------
  // Strobe, last and valid
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      strb_q  <= '0;
      last_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      if (lane_write) begin
        // Merge on top of an empty word when the old one leaves now
        strb_q <= (accept ? '0 : strb_q) | lane_strb;
      end else if (accept) begin
        strb_q <= '0;
      end
      if (word_flush) begin
        valid_q <= 1'b1;
        last_q  <= word_last;
      end else if (accept) begin
        valid_q <= 1'b0;
        last_q  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < WIDE_BYTES; b++) begin
      if (lane_write && lane_strb[b]) begin
        data_q[8*b +: 8] <= lane_data[8*b +: 8];
      end
    end
  end

  assign out_w_data  = data_q;
  assign out_w_strb  = strb_q;
  assign out_w_last  = last_q;
  assign out_w_valid = valid_q;

  assign burst_done = accept && last_q;

endmodule

`default_nettype wire

//--- sim.f
rtl/upsize_pkg.sv
rtl/aw_burst_planner.sv
rtl/w_lane_steer.sv
rtl/w_word_buffer.sv
rtl/axi_write_upsizer.sv
dv/upsizer_asserts.sv
dv/tb_axi_write_upsizer.sv
